// ==== source/l1_cache_pkg.sv ====
/*
 * Shared definitions for the L1 cache: geometry, address fields and the
 * request record that is held through the lookup cycle.
 * Modules import it inside their bodies and use scoped names in port lists.
 */
`default_nettype none

package l1_cache_pkg;
	// Four ways of 32 sets with 64-byte lines make 8 KB
	localparam int L1_NUM_WAYS = 4;
	localparam int L1_NUM_SETS = 32;
	localparam int L1_SET_INDEX_WIDTH = 5;
	localparam int L1_TAG_WIDTH = 21;
	localparam int L1_OFFSET_WIDTH = 6;
	localparam int L1_LINE_BITS = 512;

	// The core runs four hardware strands
	localparam int NUM_STRANDS = 4;

	typedef logic [L1_SET_INDEX_WIDTH-1:0] l1_set_t;
	typedef logic [L1_TAG_WIDTH-1:0] l1_tag_t;
	typedef logic [$clog2(L1_NUM_WAYS)-1:0] l1_way_t;
	typedef logic [$clog2(NUM_STRANDS)-1:0] strand_t;
	typedef logic [NUM_STRANDS-1:0] strand_mask_t;
	typedef logic [L1_LINE_BITS-1:0] line_t;

	// Core access as seen during the lookup cycle, one edge after it was made
	typedef struct packed {
		logic access;
		l1_set_t set;
		l1_tag_t tag;
		strand_t strand;
	} l1_lookup_t;

	// Bits 10..6 pick the set
	function automatic l1_set_t addr_set(input logic [31:0] address);
		return address[L1_OFFSET_WIDTH +: L1_SET_INDEX_WIDTH];
	endfunction

	// Bits 31..11 form the tag
	function automatic l1_tag_t addr_tag(input logic [31:0] address);
		return address[31 -: L1_TAG_WIDTH];
	endfunction
endpackage

`default_nettype wire

// ==== source/l2_bus_pkg.sv ====
/*
 * Request and response formats of the bus between the L1 and the shared L2.
 * The line address drops the byte offset, so it is address bits 31..6.
 */
`default_nettype none

package l2_bus_pkg;
	typedef logic [31-l1_cache_pkg::L1_OFFSET_WIDTH:0] line_addr_t;

	// Only plain loads are issued by this cache
	typedef enum logic [2:0] {
		L2_OP_LOAD = 3'd0,
		L2_OP_STORE = 3'd1,
		L2_OP_LOAD_SYNC = 3'd2
	} l2_op_e;

	typedef struct packed {
		logic [1:0] unit;
		l1_cache_pkg::strand_t strand;
		l2_op_e op;
		l1_cache_pkg::l1_way_t way;
		line_addr_t address;
		l1_cache_pkg::line_t data;
		logic [63:0] mask;
	} l2_req_t;

	// A response names its requester by unit and strand, and echoes the way
	typedef struct packed {
		logic [1:0] unit;
		l1_cache_pkg::strand_t strand;
		l1_cache_pkg::l1_way_t way;
		l1_cache_pkg::line_t data;
	} l2_rsp_t;
endpackage

`default_nettype wire

// ==== source/sram_1r1w.sv ====
/*
 * Synchronous memory with one read and one write port, used for a data way.
 * A read of the address being written in the same cycle returns the new data.
 */
`timescale 1ns/1ps
`default_nettype none

module sram_1r1w
	#(parameter int DATA_WIDTH = 32,
	parameter int SIZE = 64,
	parameter int ADDR_WIDTH = 6)
	(input logic clk,
	input logic rd_enable_i,
	input logic [ADDR_WIDTH-1:0] rd_addr_i,
	output logic [DATA_WIDTH-1:0] rd_data_o,
	input logic wr_enable_i,
	input logic [ADDR_WIDTH-1:0] wr_addr_i,
	input logic [DATA_WIDTH-1:0] wr_data_i);

	logic [DATA_WIDTH-1:0] mem [SIZE];

	always_ff @(posedge clk)
	begin
		if (wr_enable_i)
			mem[wr_addr_i] <= wr_data_i;

		// Forward the write data so a line filled this cycle reads back fresh
		if (rd_enable_i)
		begin
			if (wr_enable_i && wr_addr_i == rd_addr_i)
				rd_data_o <= wr_data_i;
			else
				rd_data_o <= mem[rd_addr_i];
		end
	end
endmodule

`default_nettype wire

// ==== source/l1_cache_tag.sv ====
/*
 * Tag and valid storage for the four ways of the L1.
 * An access reads all ways at once; one cycle later the hit flag and the
 * binary hit way come out. A fill writes the tag and marks the way valid.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tag
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic [31:0] address_i,
	input logic update_i,
	input l1_cache_pkg::l1_way_t update_way_i,
	input l1_cache_pkg::l1_set_t update_set_i,
	input l1_cache_pkg::l1_tag_t update_tag_i,
	output l1_cache_pkg::l1_way_t hit_way_o,
	output logic cache_hit_o);

	import l1_cache_pkg::*;

	// Tag arrays, one per way
	l1_tag_t tag_mem [L1_NUM_WAYS][L1_NUM_SETS];

	// One valid bit per way and set, all clear after reset
	logic [L1_NUM_WAYS-1:0][L1_NUM_SETS-1:0] line_valid;

	// Values captured at the access edge and compared in the lookup cycle
	l1_tag_t lookup_tag_q [L1_NUM_WAYS];
	logic [L1_NUM_WAYS-1:0] lookup_valid_q;
	l1_tag_t request_tag_q;
	logic access_q;
	logic [L1_NUM_WAYS-1:0] way_match;

	// Tag storage and the registered read of every way
	always_ff @(posedge clk)
	begin
		if (update_i)
			tag_mem[update_way_i][update_set_i] <= update_tag_i;

		if (access_i)
		begin
			for (int w = 0; w < L1_NUM_WAYS; w++)
				lookup_tag_q[w] <= tag_mem[w][addr_set(address_i)];
			request_tag_q <= addr_tag(address_i);
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			line_valid <= '0;
			lookup_valid_q <= '0;
			access_q <= 1'b0;
		end
		else
		begin
			// A fill makes the line usable from the next access on
			if (update_i)
				line_valid[update_way_i][update_set_i] <= 1'b1;

			if (access_i)
			begin
				for (int w = 0; w < L1_NUM_WAYS; w++)
					lookup_valid_q[w] <= line_valid[w][addr_set(address_i)];
			end

			access_q <= access_i;
		end
	end

	// At most one way matches, since the collision check keeps a line out
	// of two ways, so an OR of the way numbers gives the binary hit way
	always_comb
	begin
		hit_way_o = '0;
		for (int w = 0; w < L1_NUM_WAYS; w++)
		begin
			way_match[w] = lookup_valid_q[w] && lookup_tag_q[w] == request_tag_q;
			if (way_match[w])
				hit_way_o = hit_way_o | l1_way_t'(w);
		end
	end

	assign cache_hit_o = access_q && |way_match;
endmodule

`default_nettype wire

// ==== source/cache_lru.sv ====
/*
 * Tree pseudo-LRU for a four-way cache, three bits per set.
 * The set of an access is captured, and in the following cycle the victim
 * way of that set is given out and the MRU update is taken for it.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_lru
	#(parameter int NUM_SETS = 32,
	parameter int SET_INDEX_WIDTH = 5)
	(input logic clk,
	input logic reset,
	input logic access_i,
	input logic [SET_INDEX_WIDTH-1:0] set_i,
	input logic update_mru_i,
	input l1_cache_pkg::l1_way_t new_mru_way_i,
	output l1_cache_pkg::l1_way_t lru_way_o);

	import l1_cache_pkg::*;

	// Bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3.
	// Each bit names the half that was used most recently
	logic [2:0] tree_bits [NUM_SETS];
	logic [SET_INDEX_WIDTH-1:0] set_q;
	logic [2:0] set_bits;
	l1_way_t victim;

	assign set_bits = tree_bits[set_q];

	// The victim walk takes the half opposite to each bit
	always_comb
	begin
		victim[1] = !set_bits[0];
		if (victim[1])
			victim[0] = !set_bits[2];
		else
			victim[0] = !set_bits[1];
	end

	assign lru_way_o = victim;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			set_q <= '0;
			for (int s = 0; s < NUM_SETS; s++)
				tree_bits[s] <= 3'b000;
		end
		else
		begin
			if (access_i)
				set_q <= set_i;

			// Steer the walk away from the new MRU way, in the set looked up
			if (update_mru_i)
			begin
				tree_bits[set_q][0] <= new_mru_way_i[1];
				if (new_mru_way_i[1])
					tree_bits[set_q][2] <= new_mru_way_i[0];
				else
					tree_bits[set_q][1] <= new_mru_way_i[0];
			end
		end
	end
endmodule

`default_nettype wire

// ==== source/load_miss_queue.sv ====
/*
 * Load miss queue with one entry per strand.
 * A miss on a line that is already pending joins that entry. Entries are
 * sent to L2 one at a time in round-robin order, and a response frees the
 * entry it names and reports every strand that was waiting on the line.
 */
`timescale 1ns/1ps
`default_nettype none

module load_miss_queue
	#(parameter int UNIT_ID = 0)
	(input logic clk,
	input logic reset,
	input logic request_i,
	input l1_cache_pkg::l1_set_t set_i,
	input l1_cache_pkg::l1_tag_t tag_i,
	input l1_cache_pkg::l1_way_t victim_way_i,
	input l1_cache_pkg::strand_t strand_i,
	output logic l2req_valid_o,
	input logic l2req_ready_i,
	output l2_bus_pkg::l2_req_t l2req_o,
	input logic l2rsp_valid_i,
	input l2_bus_pkg::l2_rsp_t l2rsp_i,
	output l1_cache_pkg::strand_mask_t load_complete_strands_o,
	output l1_cache_pkg::l1_set_t load_complete_set_o,
	output l1_cache_pkg::l1_tag_t load_complete_tag_o,
	output l1_cache_pkg::l1_way_t load_complete_way_o);

	import l1_cache_pkg::*;
	import l2_bus_pkg::*;

	// Line and destination way of one pending miss
	typedef struct packed {
		l1_set_t set;
		l1_tag_t tag;
		l1_way_t way;
	} miss_line_t;

	logic [NUM_STRANDS-1:0] entry_valid;
	logic [NUM_STRANDS-1:0] entry_issued;
	strand_mask_t entry_waiting [NUM_STRANDS];
	miss_line_t entry_line [NUM_STRANDS];
	logic merge_hit;
	strand_t merge_idx;
	logic issue_found;
	strand_t issue_scan;
	strand_t issue_idx;
	strand_t rr_ptr;
	logic hold_q;
	strand_t hold_idx_q;
	logic issue_xfer;
	logic rsp_hit;
	strand_t rsp_strand;
	strand_mask_t request_bit;

	assign request_bit = strand_mask_t'(1) << strand_i;

	// Look for a pending entry on the same line
	always_comb
	begin
		merge_hit = 1'b0;
		merge_idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (entry_valid[i] && entry_line[i].set == set_i && entry_line[i].tag == tag_i)
			begin
				merge_hit = 1'b1;
				merge_idx = strand_t'(i);
			end
		end
	end

	// Scan from the round-robin pointer; the last hit found is the nearest one
	always_comb
	begin
		issue_found = 1'b0;
		issue_scan = rr_ptr;
		for (int k = NUM_STRANDS - 1; k >= 0; k--)
		begin
			if (entry_valid[strand_t'(rr_ptr + k)] && !entry_issued[strand_t'(rr_ptr + k)])
			begin
				issue_found = 1'b1;
				issue_scan = strand_t'(rr_ptr + k);
			end
		end
	end

	// A stalled request keeps its entry so the bus sees a stable struct
	assign issue_idx = hold_q ? hold_idx_q : issue_scan;
	assign l2req_valid_o = hold_q || issue_found;
	assign issue_xfer = l2req_valid_o && l2req_ready_i;

	always_comb
	begin
		l2req_o.unit = 2'(UNIT_ID);
		l2req_o.strand = issue_idx;
		l2req_o.op = L2_OP_LOAD;
		l2req_o.way = entry_line[issue_idx].way;
		l2req_o.address = line_addr_t'({entry_line[issue_idx].tag, entry_line[issue_idx].set});
		l2req_o.data = '0;
		l2req_o.mask = '0;
	end

	// The response strand names the entry that sent the request
	assign rsp_strand = l2rsp_i.strand;
	assign rsp_hit = l2rsp_valid_i && l2rsp_i.unit == 2'(UNIT_ID) && entry_valid[rsp_strand];

	assign load_complete_strands_o = rsp_hit ? entry_waiting[rsp_strand] : '0;
	assign load_complete_set_o = entry_line[rsp_strand].set;
	assign load_complete_tag_o = entry_line[rsp_strand].tag;
	assign load_complete_way_o = entry_line[rsp_strand].way;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			entry_valid <= '0;
			entry_issued <= '0;
			rr_ptr <= '0;
			hold_q <= 1'b0;
			hold_idx_q <= '0;
			for (int i = 0; i < NUM_STRANDS; i++)
				entry_waiting[i] <= '0;
		end
		else
		begin
			if (rsp_hit)
			begin
				entry_valid[rsp_strand] <= 1'b0;
				entry_issued[rsp_strand] <= 1'b0;
			end

			if (issue_xfer)
			begin
				entry_issued[issue_idx] <= 1'b1;
				rr_ptr <= strand_t'(issue_idx + 1'b1);
			end

			// Join a pending line, or take this strand's own slot
			if (request_i)
			begin
				if (merge_hit)
					entry_waiting[merge_idx] <= entry_waiting[merge_idx] | request_bit;
				else
				begin
					entry_valid[strand_i] <= 1'b1;
					entry_issued[strand_i] <= 1'b0;
					entry_waiting[strand_i] <= request_bit;
				end
			end

			hold_q <= l2req_valid_o && !l2req_ready_i;
			hold_idx_q <= issue_idx;
		end
	end

	always_ff @(posedge clk)
	begin
		if (request_i && !merge_hit)
			entry_line[strand_i] <= '{set: set_i, tag: tag_i, way: victim_way_i};
	end
endmodule

`default_nettype wire

// ==== source/l1_cache.sv ====
/*
 * Four-way virtually indexed, virtually tagged L1 cache of 8 KB.
 * Tags and all data ways are read in parallel and the result is given one
 * cycle after the access. Misses go to the load miss queue and from there
 * to the L2 over a valid/ready request bus and an unthrottled response bus.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache
	#(parameter int UNIT_ID = 0)
	(input logic clk,
	input logic reset,

	// Core side
	input logic access_i,
	input logic [31:0] address_i,
	input l1_cache_pkg::strand_t strand_i,
	output l1_cache_pkg::line_t data_o,
	output logic cache_hit_o,
	output logic load_collision_o,
	output l1_cache_pkg::strand_mask_t load_complete_strands_o,

	// L2 side
	output logic l2req_valid_o,
	input logic l2req_ready_i,
	output l2_bus_pkg::l2_req_t l2req_o,
	input logic l2rsp_valid_i,
	input l2_bus_pkg::l2_rsp_t l2rsp_i);

	import l1_cache_pkg::*;

	l1_lookup_t lookup_q;
	l1_set_t request_set;
	l1_tag_t request_tag;
	l1_way_t hit_way;
	l1_way_t lru_way;
	l1_way_t new_mru_way;
	logic tag_hit;
	logic update_mru;
	logic queue_load;
	logic fill_active;
	logic collision_access_q;
	logic collision_lookup;
	l1_set_t load_complete_set;
	l1_tag_t load_complete_tag;
	l1_way_t load_complete_way;
	line_t way_data [L1_NUM_WAYS];

	assign request_set = addr_set(address_i);
	assign request_tag = addr_tag(address_i);

	// A completion writes tags and data at the end of this cycle
	assign fill_active = |load_complete_strands_o;

	l1_cache_tag tag_mem (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.address_i(address_i),
		.update_i(fill_active),
		.update_way_i(load_complete_way),
		.update_set_i(load_complete_set),
		.update_tag_i(load_complete_tag),
		.hit_way_o(hit_way),
		.cache_hit_o(tag_hit));

	for (genvar w = 0; w < L1_NUM_WAYS; w++)
	begin : gen_way
		sram_1r1w #(
			.DATA_WIDTH(L1_LINE_BITS),
			.SIZE(L1_NUM_SETS),
			.ADDR_WIDTH(L1_SET_INDEX_WIDTH)) way_data_mem (
			.clk(clk),
			.rd_enable_i(access_i),
			.rd_addr_i(request_set),
			.rd_data_o(way_data[w]),
			.wr_enable_i(fill_active && load_complete_way == l1_way_t'(w)),
			.wr_addr_i(load_complete_set),
			.wr_data_i(l2rsp_i.data));
	end

	// All ways were read; the tag compare picks the one to return
	assign data_o = way_data[hit_way];
	assign cache_hit_o = tag_hit;

	// A line filled in the lookup cycle was still absent when the tags were read
	assign collision_lookup = fill_active && lookup_q.access
		&& load_complete_set == lookup_q.set && load_complete_tag == lookup_q.tag;
	assign load_collision_o = collision_access_q || collision_lookup;

	// Queue a miss unless the line is landing now, which would put it in two ways
	assign queue_load = lookup_q.access && !tag_hit && !load_collision_o;

	// A hit becomes MRU, and a queued miss protects its victim way until the fill
	assign new_mru_way = tag_hit ? hit_way : lru_way;
	assign update_mru = tag_hit || queue_load;

	cache_lru #(
		.NUM_SETS(L1_NUM_SETS),
		.SET_INDEX_WIDTH(L1_SET_INDEX_WIDTH)) lru (
		.clk(clk),
		.reset(reset),
		.access_i(access_i),
		.set_i(request_set),
		.update_mru_i(update_mru),
		.new_mru_way_i(new_mru_way),
		.lru_way_o(lru_way));

	load_miss_queue #(.UNIT_ID(UNIT_ID)) miss_queue (
		.clk(clk),
		.reset(reset),
		.request_i(queue_load),
		.set_i(lookup_q.set),
		.tag_i(lookup_q.tag),
		.victim_way_i(lru_way),
		.strand_i(lookup_q.strand),
		.l2req_valid_o(l2req_valid_o),
		.l2req_ready_i(l2req_ready_i),
		.l2req_o(l2req_o),
		.l2rsp_valid_i(l2rsp_valid_i),
		.l2rsp_i(l2rsp_i),
		.load_complete_strands_o(load_complete_strands_o),
		.load_complete_set_o(load_complete_set),
		.load_complete_tag_o(load_complete_tag),
		.load_complete_way_o(load_complete_way));

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			lookup_q <= '0;
			collision_access_q <= 1'b0;
		end
		else
		begin
			lookup_q <= '{access: access_i, set: request_set, tag: request_tag,
				strand: strand_i};

			// A line filled in the access cycle is written at the same edge as the tag read
			collision_access_q <= access_i && fill_active
				&& load_complete_set == request_set && load_complete_tag == request_tag;
		end
	end
endmodule

`default_nettype wire

// ==== tb/l1_cache_sva.sv ====
/*
 * Concurrent checks bound to every l1_cache instance.
 * They cover the L2 request handshake, the completion pulse and the miss
 * queue rule that a line is held by at most one entry.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_sva
	#(parameter int UNIT_ID = 0)
	(input logic clk,
	input logic reset,
	input logic l2req_valid_o,
	input logic l2req_ready_i,
	input l2_bus_pkg::l2_req_t l2req_o,
	input logic l2rsp_valid_i,
	input l2_bus_pkg::l2_rsp_t l2rsp_i,
	input l1_cache_pkg::strand_mask_t load_complete_strands_o,
	input logic [l1_cache_pkg::NUM_STRANDS-1:0] entry_valid_i,
	input logic [27:0] entry_line_i [l1_cache_pkg::NUM_STRANDS]);

	import l1_cache_pkg::*;

	// An entry is set, tag and way from the top down, so the line sits above the way
	localparam int WAY_BITS = $clog2(L1_NUM_WAYS);

	logic line_dup;

	// Set once any of the rules below is broken
	logic assert_failed;

	initial
		assert_failed = 1'b0;

	always_comb
	begin
		line_dup = 1'b0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			for (int j = i + 1; j < NUM_STRANDS; j++)
			begin
				if (entry_valid_i[i] && entry_valid_i[j]
					&& entry_line_i[i][27:WAY_BITS] == entry_line_i[j][27:WAY_BITS])
					line_dup = 1'b1;
			end
		end
	end

	// A stalled request keeps valid high and every field unchanged
	request_stable: assert property (@(posedge clk) disable iff (reset)
		l2req_valid_o && !l2req_ready_i |=> l2req_valid_o && $stable(l2req_o))
	else
	begin
		$error("L2 request changed or dropped while stalled");
		assert_failed = 1'b1;
	end

	// Every response for this unit completes its strands in that same cycle,
	// and no strand completes without one
	completion_with_response: assert property (@(posedge clk) disable iff (reset)
		(|load_complete_strands_o) == (l2rsp_valid_i && l2rsp_i.unit == 2'(UNIT_ID)))
	else
	begin
		$error("completion mask does not follow the L2 response for this unit");
		assert_failed = 1'b1;
	end

	// Merging must keep a second entry from asking for the same line
	single_entry_per_line: assert property (@(posedge clk) disable iff (reset)
		!line_dup)
	else
	begin
		$error("two miss queue entries hold the same line");
		assert_failed = 1'b1;
	end
endmodule

bind l1_cache l1_cache_sva #(.UNIT_ID(UNIT_ID)) sva (
	.clk(clk),
	.reset(reset),
	.l2req_valid_o(l2req_valid_o),
	.l2req_ready_i(l2req_ready_i),
	.l2req_o(l2req_o),
	.l2rsp_valid_i(l2rsp_valid_i),
	.l2rsp_i(l2rsp_i),
	.load_complete_strands_o(load_complete_strands_o),
	.entry_valid_i(miss_queue.entry_valid),
	.entry_line_i(miss_queue.entry_line));

`default_nettype wire

// ==== tb/l1_cache_tb.sv ====
/*
 * Testbench for the L1 cache. Reads access commands from the vector file,
 * plays the L2 with a reactive model that answers after a random delay, and
 * checks hits, collisions, fill data, L2 requests and completion masks.
 * Run from the project root so the vector file path resolves.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb;
	import l1_cache_pkg::*;
	import l2_bus_pkg::*;

	localparam int UNIT_ID = 1;
	localparam int RESET_CYCLES = 16;
	localparam int L2_MIN_DELAY = 3;
	localparam int L2_MAX_DELAY = 18;
	localparam int MAX_VECTORS = 64;

	// One core access and what its lookup cycle must show
	typedef struct packed {
		logic valid;
		strand_t strand;
		logic [31:0] address;
		logic hit;
		logic coll;
	} access_t;

	logic clk;
	logic reset;
	logic access;
	logic [31:0] address;
	strand_t strand;
	line_t data;
	logic cache_hit;
	logic load_collision;
	strand_mask_t complete_strands;
	logic l2req_valid;
	logic l2req_ready;
	l2_req_t l2req;
	logic l2rsp_valid;
	l2_rsp_t l2rsp;

	logic [47:0] vectors [MAX_VECTORS];
	integer seed;
	int cycle;
	int timeout_limit;
	int stall_left;
	access_t next_acc;
	access_t drive_acc;
	access_t lookup_acc;
	logic req_stalled;
	l2_req_t stalled_req;

	// The L2 model answers the requests it took in order, each when it is due
	line_addr_t l2_line [$];
	strand_t l2_strand [$];
	l1_way_t l2_way [$];
	int l2_due [$];
	int last_due;
	logic rsp_active;
	line_addr_t rsp_line;

	// Lines the core is waiting on and the strands that joined each one
	line_addr_t pend_line [$];
	strand_mask_t pend_mask [$];
	strand_t pend_strand [$];
	logic pend_issued [$];

	l1_cache #(.UNIT_ID(UNIT_ID)) uut (
		.clk(clk),
		.reset(reset),
		.access_i(access),
		.address_i(address),
		.strand_i(strand),
		.data_o(data),
		.cache_hit_o(cache_hit),
		.load_collision_o(load_collision),
		.load_complete_strands_o(complete_strands),
		.l2req_valid_o(l2req_valid),
		.l2req_ready_i(l2req_ready),
		.l2req_o(l2req),
		.l2rsp_valid_i(l2rsp_valid),
		.l2rsp_i(l2rsp));

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	// Word k of a line holds the line address shifted left by 4, plus k
	function automatic line_t line_pattern(input line_addr_t line);
		line_t fill;
		for (int k = 0; k < 16; k++)
			fill[k*32 +: 32] = (32'(line) << 4) + 32'(k);
		return fill;
	endfunction

	function automatic int find_pending(input line_addr_t line);
		for (int i = 0; i < pend_line.size(); i++)
		begin
			if (pend_line[i] == line)
				return i;
		end
		return -1;
	endfunction

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "run stopped at cycle %0d", cycle);
	endtask

	task automatic report_problem(input string msg);
		$display("Error: %s", msg);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [639:0] got,
		input logic [639:0] expected);
		if (got !== expected)
		begin
			$display("[FAIL] %s: got %0h, expected %0h", name, got, expected);
			abort_run();
		end
	endtask

	// A second strand on a pending line only joins its mask
	task automatic record_miss(input line_addr_t line, input strand_t s);
		int idx;
		idx = find_pending(line);
		if (idx >= 0)
			pend_mask[idx] = pend_mask[idx] | (strand_mask_t'(1) << s);
		else
		begin
			pend_line.push_back(line);
			pend_mask.push_back(strand_mask_t'(1) << s);
			pend_strand.push_back(s);
			pend_issued.push_back(1'b0);
		end
	endtask

	task automatic accept_request();
		int idx;
		int delay;
		idx = find_pending(l2req.address);
		if (idx < 0 || pend_issued[idx])
			report_problem("L2 request for a line with no unissued miss");
		else
		begin
			check_value("l2req_o.unit", l2req.unit, 2'(UNIT_ID));
			check_value("l2req_o.op", l2req.op, L2_OP_LOAD);
			check_value("l2req_o.strand", l2req.strand, pend_strand[idx]);
			check_value("l2req_o.data", l2req.data, '0);
			check_value("l2req_o.mask", l2req.mask, '0);
			pend_issued[idx] = 1'b1;
			delay = L2_MIN_DELAY
				+ int'($unsigned($random(seed)) % (L2_MAX_DELAY - L2_MIN_DELAY + 1));
			// Transfer happens at the next edge; answers stay in order
			last_due = (cycle + 1 + delay > last_due) ? cycle + 1 + delay : last_due + 1;
			l2_line.push_back(l2req.address);
			l2_strand.push_back(l2req.strand);
			l2_way.push_back(l2req.way);
			l2_due.push_back(last_due);
		end
	endtask

	task automatic check_completion();
		int idx;
		if (rsp_active)
		begin
			idx = find_pending(rsp_line);
			if (idx < 0)
				report_problem("L2 model answered a line with no pending miss");
			else
			begin
				check_value("load_complete_strands_o", complete_strands, pend_mask[idx]);
				pend_line.delete(idx);
				pend_mask.delete(idx);
				pend_strand.delete(idx);
				pend_issued.delete(idx);
			end
		end
		else
			check_value("load_complete_strands_o", complete_strands, '0);
	endtask

	// Everything is sampled at the falling edge, half a cycle after the drive
	task automatic sample_outputs();
		if (uut.sva.assert_failed)
			report_problem("a bound assertion on the cache failed");
		check_completion();
		if (lookup_acc.valid)
		begin
			check_value("cache_hit_o", cache_hit, lookup_acc.hit);
			check_value("load_collision_o", load_collision, lookup_acc.coll);
			if (lookup_acc.hit)
				check_value("data_o", data, line_pattern(lookup_acc.address[31:6]));
			else if (!lookup_acc.coll)
				record_miss(lookup_acc.address[31:6], lookup_acc.strand);
		end
		else
		begin
			check_value("cache_hit_o", cache_hit, 1'b0);
			check_value("load_collision_o", load_collision, 1'b0);
		end

		if (req_stalled)
		begin
			check_value("l2req_valid_o", l2req_valid, 1'b1);
			check_value("l2req_o", l2req, stalled_req);
		end
		req_stalled = l2req_valid && !l2req_ready;
		stalled_req = l2req;
		if (l2req_valid && l2req_ready)
			accept_request();
	endtask

	task automatic drive_cycle();
		lookup_acc = drive_acc;
		drive_acc = next_acc;
		next_acc = '0;
		access <= drive_acc.valid;
		address <= drive_acc.address;
		strand <= drive_acc.strand;

		l2req_ready <= (stall_left == 0);
		if (stall_left > 0)
			stall_left--;

		rsp_active = 1'b0;
		if (l2_due.size() > 0)
			rsp_active = l2_due[0] <= cycle;
		l2rsp_valid <= rsp_active;
		if (rsp_active)
		begin
			rsp_line = l2_line[0];
			l2rsp <= '{unit: 2'(UNIT_ID), strand: l2_strand[0], way: l2_way[0],
				data: line_pattern(l2_line[0])};
			void'(l2_line.pop_front());
			void'(l2_strand.pop_front());
			void'(l2_way.pop_front());
			void'(l2_due.pop_front());
		end
	endtask

	task automatic tick();
		@(posedge clk);
		cycle++;
		if (cycle > timeout_limit)
			report_problem("timeout, the cache stopped making progress");
		else
		begin
			drive_cycle();
			@(negedge clk);
			sample_outputs();
		end
	endtask

	// Run until every miss is answered and the request bus is quiet
	task automatic drain();
		while (pend_line.size() != 0 || l2_due.size() != 0 || drive_acc.valid
			|| lookup_acc.valid)
			tick();
		check_value("l2req_valid_o", l2req_valid, 1'b0);
	endtask

	task automatic run_access(input logic [47:0] vec);
		// A collision access is timed so the fill lands in its lookup cycle
		if (vec[0])
		begin
			while (l2_due.size() == 0 || l2_due[0] > cycle + 2)
				tick();
			if (l2_due[0] != cycle + 2)
				report_problem("no L2 response could be lined up with the collision access");
		end
		next_acc = '{valid: 1'b1, strand: strand_t'(vec[43:40]), address: vec[39:8],
			hit: vec[4], coll: vec[0]};
		tick();
	endtask

	initial
	begin
		int vec_count;
		logic [47:0] vec;
		seed = 45999;
		cycle = 0;
		stall_left = 0;
		last_due = 0;
		next_acc = '0;
		drive_acc = '0;
		lookup_acc = '0;
		req_stalled = 1'b0;
		rsp_active = 1'b0;
		reset = 1'b1;
		access = 1'b0;
		address = '0;
		strand = '0;
		l2req_ready = 1'b1;
		l2rsp_valid = 1'b0;
		l2rsp = '0;

		$readmemh("tb/l1_cache_vectors.hex", vectors);
		vec_count = 0;
		while (vec_count < MAX_VECTORS && vectors[vec_count][47:44] !== 4'hf)
			vec_count++;
		timeout_limit = RESET_CYCLES + vec_count * (L2_MAX_DELAY + 24);
		if (vec_count == MAX_VECTORS)
			report_problem("vector file has no end command");

		repeat (RESET_CYCLES - 1)
			@(posedge clk);
		@(negedge clk);
		check_value("l2req_valid_o", l2req_valid, 1'b0);
		check_value("cache_hit_o", cache_hit, 1'b0);
		check_value("load_collision_o", load_collision, 1'b0);
		check_value("load_complete_strands_o", complete_strands, '0);
		@(posedge clk);
		reset <= 1'b0;

		for (int i = 0; i < vec_count; i++)
		begin
			vec = vectors[i];
			case (vec[47:44])
				4'h1: run_access(vec);
				4'h2: drain();
				4'h3: stall_left = int'(vec[39:8]);
				default: report_problem("unknown command in the vector file");
			endcase
		end
		drain();
		$display("=== PASS ===");
		$finish;
	end
endmodule

`default_nettype wire

// ==== l1_cache.f ====
source/l1_cache_pkg.sv
source/l2_bus_pkg.sv
source/sram_1r1w.sv
source/l1_cache_tag.sv
source/cache_lru.sv
source/load_miss_queue.sv
source/l1_cache.sv
tb/l1_cache_sva.sv
tb/l1_cache_tb.sv

// ==== tb/l1_cache_vectors.hex ====
// Columns: command, strand, address (or cycle count), expected hit, expected collision
// Commands: 1 access, 2 drain until idle, 3 hold L2 ready low for count cycles, f end
101234567800 // cold miss on strand 0
200000000000
101234564010 // same line now hits
110000094000 // five lines in set 5, A goes to way 3
200000000000
110000114000 // B to way 1
200000000000
110000194000 // C to way 2
200000000000
110000214000 // D to way 0
200000000000
110000294000 // E evicts A from way 3
200000000000
110000114010 // B still present
110000094000 // A was the victim, misses again
200000000000
110000294010
110000114010
110000094010
110000194000 // C was pushed out by the refill of A
200000000000
120ABCD00000 // strands 2 and 3 miss one line back to back
130ABCD00800
200000000000
100ABCD03010
300000000A00 // L2 ready low for 10 cycles
100040008000
110080010000
200000000000
1000C0018000 // miss on strand 0, then strand 3 meets the fill
1300C0018801
200000000000
1300C0018810
F00000000000
